// ==== compile.f ====
+incdir+hw
hw/fetch_pkg.sv
hw/bus_if.sv
hw/ibus_aligner.sv
hw/bus_arbiter.sv
hw/wb_ram.sv
hw/fetch_top.sv
dv/tb_fetch_top.sv

// ==== dv/tb_fetch_top.sv ====
`timescale 1ns/1ps
`include "fetch_defs.svh"

module tb_fetch_top;

    localparam int RAM_WORDS      = `FETCH_RAM_WORDS;
    localparam int TIMEOUT_CYCLES = 64;
    localparam int DRIVE_DLY      = 5;
    localparam int MIX_OPS        = 300;
    localparam int FETCH_OPS      = 200;
    localparam int BUSY_OPS       = 1000;
    // Shared hot region straddles the top of the RAM
    localparam int HOT_BASE       = RAM_WORDS - 4;
    localparam int HOT_SPAN       = 8;

    logic             clk;
    logic             rst;
    fetch_pkg::addr_t i_ibus_adr;
    logic             i_ibus_cyc;
    fetch_pkg::word_t o_ibus_rdt;
    logic             o_ibus_ack;
    fetch_pkg::addr_t i_dbus_adr;
    fetch_pkg::word_t i_dbus_dat;
    fetch_pkg::sel_t  i_dbus_sel;
    logic             i_dbus_we;
    logic             i_dbus_cyc;
    fetch_pkg::word_t o_dbus_rdt;
    logic             o_dbus_ack;

    // Reference memory, updated when a write is acknowledged
    fetch_pkg::word_t    model [RAM_WORDS];

    // Fetch in flight and every value its words held meanwhile
    logic                fetch_busy;
    logic                fetch_mis;
    fetch_pkg::ram_idx_t fetch_idx_a;
    fetch_pkg::ram_idx_t fetch_idx_b;
    fetch_pkg::word_t    cand_a [$];
    fetch_pkg::word_t    cand_b [$];

    logic timed_out;
    int   n_checks   = 0;
    int   n_errors   = 0;
    int   n_timeouts = 0;
    int   ibus_reqs  = 0;
    int   dbus_reqs  = 0;
    int   ibus_acks  = 0;
    int   dbus_acks  = 0;

    fetch_top #(
        .ALIGN (1)
    ) fetch_top_inst (
        .clk        (clk),
        .rst        (rst),
        .i_ibus_adr (i_ibus_adr),
        .i_ibus_cyc (i_ibus_cyc),
        .o_ibus_rdt (o_ibus_rdt),
        .o_ibus_ack (o_ibus_ack),
        .i_dbus_adr (i_dbus_adr),
        .i_dbus_dat (i_dbus_dat),
        .i_dbus_sel (i_dbus_sel),
        .i_dbus_we  (i_dbus_we),
        .i_dbus_cyc (i_dbus_cyc),
        .o_dbus_rdt (o_dbus_rdt),
        .o_dbus_ack (o_dbus_ack)
    );

    always #50 clk = ~clk;

    // Ack pulses, compared with request counts at the end
    always @(negedge clk) begin
        if (rst === 1'b0) begin
            if (o_ibus_ack === 1'b1) begin
                ibus_acks++;
            end
            if (o_dbus_ack === 1'b1) begin
                dbus_acks++;
            end
        end
    end

    task automatic check_word(input string name, input fetch_pkg::word_t got,
                              input fetch_pkg::word_t exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("CHECK FAILED at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        n_checks++;
        if (got !== exp) begin
            n_errors++;
            $display("CHECK FAILED at %0t: %s got %b expected %b", $time, name, got, exp);
        end
    endtask

    task automatic report_timeout(input string what);
        n_timeouts++;
        timed_out = 1'b1;
        $display("ERROR at %0t: no %s within %0d cycles", $time, what, TIMEOUT_CYCLES);
    endtask

    function automatic fetch_pkg::addr_t byte_addr(input fetch_pkg::ram_idx_t idx,
                                                   input logic upper_half);
        return fetch_pkg::addr_t'({idx, upper_half, 1'b0});
    endfunction

    // Upper half of the first word low, lower half of the next word high
    function automatic fetch_pkg::word_t join_halves(input fetch_pkg::word_t first,
                                                     input fetch_pkg::word_t second);
        return {second[15:0], first[31:16]};
    endfunction

    // Latest model value unless an earlier one explains the fetch
    function automatic fetch_pkg::word_t fetch_expect(input fetch_pkg::word_t got);
        fetch_pkg::word_t exp;
        if (!fetch_mis) begin
            exp = cand_a[cand_a.size()-1];
            foreach (cand_a[i]) begin
                if (cand_a[i] == got) begin
                    exp = cand_a[i];
                end
            end
        end else begin
            exp = join_halves(cand_a[cand_a.size()-1], cand_b[cand_b.size()-1]);
            foreach (cand_a[i]) begin
                foreach (cand_b[j]) begin
                    if (join_halves(cand_a[i], cand_b[j]) == got) begin
                        exp = join_halves(cand_a[i], cand_b[j]);
                    end
                end
            end
        end
        return exp;
    endfunction

    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge clk);
            #DRIVE_DLY;
        end
    endtask

    task automatic dbus_access(input fetch_pkg::addr_t adr, input fetch_pkg::word_t dat,
                               input fetch_pkg::sel_t sel, input logic we);
        fetch_pkg::ram_idx_t idx;
        int                  waited;
        logic                seen;
        if (timed_out) begin
            return;
        end
        idx        = adr[`FETCH_RAM_AW+1:2];
        i_dbus_adr = adr;
        i_dbus_dat = dat;
        i_dbus_sel = sel;
        i_dbus_we  = we;
        i_dbus_cyc = 1'b1;
        dbus_reqs++;
        waited = 0;
        seen   = 1'b0;
        while (!seen && waited < TIMEOUT_CYCLES) begin
            @(negedge clk);
            if (o_dbus_ack === 1'b1) begin
                seen = 1'b1;
            end else begin
                waited++;
            end
        end
        if (!seen) begin
            report_timeout("o_dbus_ack");
        end else begin
            if (we) begin
                for (int b = 0; b < 4; b++) begin
                    if (sel[b]) begin
                        model[idx][8*b +: 8] = dat[8*b +: 8];
                    end
                end
                if (fetch_busy && idx == fetch_idx_a) begin
                    cand_a.push_back(model[idx]);
                end
                if (fetch_busy && idx == fetch_idx_b) begin
                    cand_b.push_back(model[idx]);
                end
            end else begin
                check_word("o_dbus_rdt", o_dbus_rdt, model[idx]);
            end
            @(posedge clk);
            #DRIVE_DLY;
            i_dbus_cyc = 1'b0;
            i_dbus_we  = 1'b0;
        end
    endtask

    task automatic fetch(input fetch_pkg::addr_t adr);
        int   waited;
        logic seen;
        if (timed_out) begin
            return;
        end
        fetch_mis   = adr[1];
        fetch_idx_a = adr[`FETCH_RAM_AW+1:2];
        fetch_idx_b = fetch_pkg::ram_idx_t'(fetch_idx_a + 1);
        cand_a.delete();
        cand_b.delete();
        cand_a.push_back(model[fetch_idx_a]);
        cand_b.push_back(model[fetch_idx_b]);
        fetch_busy = 1'b1;
        i_ibus_adr = adr;
        i_ibus_cyc = 1'b1;
        ibus_reqs++;
        waited = 0;
        seen   = 1'b0;
        while (!seen && waited < TIMEOUT_CYCLES) begin
            @(negedge clk);
            if (o_ibus_ack === 1'b1) begin
                seen = 1'b1;
            end else begin
                waited++;
            end
        end
        fetch_busy = 1'b0;
        if (!seen) begin
            report_timeout("o_ibus_ack");
        end else begin
            check_word("o_ibus_rdt", o_ibus_rdt, fetch_expect(o_ibus_rdt));
            @(posedge clk);
            #DRIVE_DLY;
            i_ibus_cyc = 1'b0;
        end
    endtask

    task automatic run_fetch_unit();
        fetch_pkg::ram_idx_t idx;
        for (int k = 0; k < BUSY_OPS && !timed_out; k++) begin
            idx = fetch_pkg::ram_idx_t'(HOT_BASE + $urandom_range(0, HOT_SPAN - 1));
            fetch(byte_addr(idx, $urandom_range(0, 1) == 1));
            idle_cycles($urandom_range(0, 3));
        end
    endtask

    task automatic run_load_store_unit();
        fetch_pkg::ram_idx_t idx;
        fetch_pkg::sel_t     sel;
        for (int k = 0; k < BUSY_OPS && !timed_out; k++) begin
            // Half the traffic hits the words being fetched
            if ($urandom_range(0, 1) == 1) begin
                idx = fetch_pkg::ram_idx_t'(HOT_BASE + $urandom_range(0, HOT_SPAN - 1));
            end else begin
                idx = fetch_pkg::ram_idx_t'($urandom_range(0, RAM_WORDS - 1));
            end
            if ($urandom_range(0, 1) == 1) begin
                sel = fetch_pkg::sel_t'($urandom_range(1, 15));
                dbus_access(byte_addr(idx, 1'b0), fetch_pkg::word_t'($urandom()), sel, 1'b1);
            end else begin
                dbus_access(byte_addr(idx, 1'b0), '0, '1, 1'b0);
            end
            idle_cycles($urandom_range(0, 3));
        end
    endtask

    task automatic reset_and_check();
        rst = 1'b1;
        // Sixteen rising edges in reset, flops unknown before the first one
        @(posedge clk);
        repeat (15) begin
            @(negedge clk);
            check_bit("o_ibus_ack", o_ibus_ack, 1'b0);
            check_bit("o_dbus_ack", o_dbus_ack, 1'b0);
            @(posedge clk);
        end
        #DRIVE_DLY;
        rst = 1'b0;
        @(negedge clk);
        check_bit("o_ibus_ack", o_ibus_ack, 1'b0);
        check_bit("o_dbus_ack", o_dbus_ack, 1'b0);
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    initial begin
        int unsigned         seed_ret;
        fetch_pkg::ram_idx_t idx;
        seed_ret    = $urandom(32'hf0a4);
        clk         = 1'b0;
        rst         = 1'b1;
        i_ibus_adr  = '0;
        i_ibus_cyc  = 1'b0;
        i_dbus_adr  = '0;
        i_dbus_dat  = '0;
        i_dbus_sel  = '0;
        i_dbus_we   = 1'b0;
        i_dbus_cyc  = 1'b0;
        fetch_busy  = 1'b0;
        fetch_mis   = 1'b0;
        fetch_idx_a = '0;
        fetch_idx_b = '0;
        timed_out   = 1'b0;

        reset_and_check();

        // Full-word preload of the whole RAM
        for (int w = 0; w < RAM_WORDS; w++) begin
            dbus_access(byte_addr(fetch_pkg::ram_idx_t'(w), 1'b0),
                        fetch_pkg::word_t'($urandom()), '1, 1'b1);
        end

        // Partial writes mixed with reads
        for (int k = 0; k < MIX_OPS; k++) begin
            idx = fetch_pkg::ram_idx_t'($urandom_range(0, RAM_WORDS - 1));
            if ($urandom_range(0, 1) == 1) begin
                dbus_access(byte_addr(idx, 1'b0), fetch_pkg::word_t'($urandom()),
                            fetch_pkg::sel_t'($urandom_range(1, 15)), 1'b1);
            end else begin
                dbus_access(byte_addr(idx, 1'b0), '0, '1, 1'b0);
            end
            idle_cycles($urandom_range(0, 3));
        end

        // Aligned and misaligned fetches on a quiet bus
        for (int k = 0; k < FETCH_OPS; k++) begin
            idx = fetch_pkg::ram_idx_t'($urandom_range(0, RAM_WORDS - 1));
            fetch(byte_addr(idx, $urandom_range(0, 1) == 1));
            idle_cycles($urandom_range(0, 3));
        end

        // Second half comes from word 0
        fetch(byte_addr(fetch_pkg::ram_idx_t'(RAM_WORDS - 1), 1'b1));
        idle_cycles(2);

        fork
            run_fetch_unit();
            run_load_store_unit();
        join

        repeat (4) begin
            @(posedge clk);
        end
        if (ibus_acks != ibus_reqs) begin
            n_errors++;
            $display("ERROR: %0d fetch requests but %0d o_ibus_ack pulses",
                     ibus_reqs, ibus_acks);
        end
        if (dbus_acks != dbus_reqs) begin
            n_errors++;
            $display("ERROR: %0d data requests but %0d o_dbus_ack pulses",
                     dbus_reqs, dbus_acks);
        end
        $display("checks %0d, errors %0d, timeouts %0d", n_checks, n_errors, n_timeouts);
        if (n_errors == 0 && n_timeouts == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

// ==== hw/bus_arbiter.sv ====
`timescale 1ns/1ps

module bus_arbiter (
    input  logic  clk,
    input  logic  rst,
    ibus_if.slave i_ibus,
    mem_if.slave  i_dbus,
    mem_if.master o_mem
);

    logic locked;
    logic grant_dbus_q;
    logic grant_dbus;

    // Data bus wins when nothing is in flight
    assign grant_dbus = locked ? grant_dbus_q : i_dbus.cyc;

    always_ff @(posedge clk) begin
        if (rst) begin
            locked       <= 1'b0;
            grant_dbus_q <= 1'b0;
        end else if (!locked && o_mem.cyc) begin
            locked       <= 1'b1;
            grant_dbus_q <= grant_dbus;
        end else if (o_mem.ack) begin
            locked <= 1'b0;
        end
    end

    // Request steering, instruction side is a full-word read
    always_comb begin
        if (grant_dbus) begin
            o_mem.adr = i_dbus.adr;
            o_mem.dat = i_dbus.dat;
            o_mem.sel = i_dbus.sel;
            o_mem.we  = i_dbus.we;
            o_mem.cyc = i_dbus.cyc;
        end else begin
            o_mem.adr = i_ibus.adr;
            o_mem.dat = '0;
            o_mem.sel = '1;
            o_mem.we  = 1'b0;
            o_mem.cyc = i_ibus.cyc;
        end
    end

    // Response goes back to the owner only
    assign i_dbus.rdt = grant_dbus ? o_mem.rdt : '0;
    assign i_dbus.ack = grant_dbus & o_mem.ack;
    assign i_ibus.rdt = grant_dbus ? '0 : o_mem.rdt;
    assign i_ibus.ack = ~grant_dbus & o_mem.ack;

endmodule

// ==== hw/bus_if.sv ====
`timescale 1ns/1ps

// Read-only instruction bus
interface ibus_if;
    fetch_pkg::addr_t adr;
    logic             cyc;
    fetch_pkg::word_t rdt;
    logic             ack;

    modport master (output adr, output cyc, input rdt, input ack);
    modport slave  (input adr, input cyc, output rdt, output ack);
endinterface

// Full memory bus with byte enables
interface mem_if;
    fetch_pkg::addr_t adr;
    fetch_pkg::word_t dat;
    fetch_pkg::sel_t  sel;
    logic             we;
    logic             cyc;
    fetch_pkg::word_t rdt;
    logic             ack;

    modport master (
        output adr, output dat, output sel, output we, output cyc,
        input  rdt, input  ack
    );
    modport slave (
        input  adr, input  dat, input  sel, input  we, input  cyc,
        output rdt, output ack
    );
endinterface

// ==== hw/fetch_defs.svh ====
`ifndef FETCH_DEFS_SVH
`define FETCH_DEFS_SVH

// Bus and data width in bits
`define FETCH_XLEN 32

// Word RAM depth
`define FETCH_RAM_WORDS 1024

// Word index width, log2 of the depth
`define FETCH_RAM_AW 10

`endif

// ==== hw/fetch_pkg.sv ====
`include "fetch_defs.svh"

package fetch_pkg;

    // Byte address as seen on every bus
    typedef logic [`FETCH_XLEN-1:0] addr_t;

    // Data or instruction word
    typedef logic [`FETCH_XLEN-1:0] word_t;

    // Upper half of the first word of a misaligned fetch
    typedef logic [`FETCH_XLEN/2-1:0] half_t;

    // One enable per byte lane
    typedef logic [`FETCH_XLEN/8-1:0] sel_t;

    // Word index, address bits above the byte offset
    typedef logic [`FETCH_RAM_AW-1:0] ram_idx_t;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_FIRST,
        ST_SECOND
    } align_state_e;

endpackage

// ==== hw/fetch_top.sv ====
`timescale 1ns/1ps

module fetch_top #(
    parameter int ALIGN = 1
) (
    input  logic             clk,
    input  logic             rst,

    // Instruction fetch from the core
    input  fetch_pkg::addr_t i_ibus_adr,
    input  logic             i_ibus_cyc,
    output fetch_pkg::word_t o_ibus_rdt,
    output logic             o_ibus_ack,

    // Load/store from the core
    input  fetch_pkg::addr_t i_dbus_adr,
    input  fetch_pkg::word_t i_dbus_dat,
    input  fetch_pkg::sel_t  i_dbus_sel,
    input  logic             i_dbus_we,
    input  logic             i_dbus_cyc,
    output fetch_pkg::word_t o_dbus_rdt,
    output logic             o_dbus_ack
);

    ibus_if core_ibus ();
    ibus_if al_ibus ();
    mem_if  dbus ();
    mem_if  ram_bus ();

    // Core fetch side
    assign core_ibus.adr = i_ibus_adr;
    assign core_ibus.cyc = i_ibus_cyc;
    assign o_ibus_rdt    = core_ibus.rdt;
    assign o_ibus_ack    = core_ibus.ack;

    // Core data side
    assign dbus.adr   = i_dbus_adr;
    assign dbus.dat   = i_dbus_dat;
    assign dbus.sel   = i_dbus_sel;
    assign dbus.we    = i_dbus_we;
    assign dbus.cyc   = i_dbus_cyc;
    assign o_dbus_rdt = dbus.rdt;
    assign o_dbus_ack = dbus.ack;

    // Halfword-aligned fetches split into two word reads
    ibus_aligner #(
        .ALIGN (ALIGN)
    ) ibus_aligner_inst (
        .clk    (clk),
        .rst    (rst),
        .i_core (core_ibus.slave),
        .o_mem  (al_ibus.master)
    );

    // Data bus has priority on the shared port
    bus_arbiter bus_arbiter_inst (
        .clk    (clk),
        .rst    (rst),
        .i_ibus (al_ibus.slave),
        .i_dbus (dbus.slave),
        .o_mem  (ram_bus.master)
    );

    wb_ram wb_ram_inst (
        .clk   (clk),
        .rst   (rst),
        .i_bus (ram_bus.slave)
    );

endmodule

// ==== hw/ibus_aligner.sv ====
`timescale 1ns/1ps

module ibus_aligner #(
    parameter int ALIGN = 1
) (
    input  logic   clk,
    input  logic   rst,
    ibus_if.slave  i_core,
    ibus_if.master o_mem
);

    generate
        if (ALIGN != 0) begin : g_align
            localparam int HW = $bits(fetch_pkg::half_t);
            localparam int XW = $bits(fetch_pkg::word_t);

            fetch_pkg::align_state_e state;
            fetch_pkg::align_state_e next_state;
            fetch_pkg::half_t        hold_hi;
            fetch_pkg::addr_t        word_adr;
            fetch_pkg::word_t        joined_rdt;
            logic                    misaligned;
            logic                    addr_next;
            logic                    ack_en;
            logic                    join_rdt;
            logic                    cyc_en;
            logic                    load_hold;

            assign misaligned = i_core.adr[1];

            // Byte offset dropped, RAM ignores it anyway
            assign word_adr = i_core.adr & ~fetch_pkg::addr_t'(3);

            // Datapath
            assign o_mem.adr = addr_next ? word_adr + fetch_pkg::addr_t'(4) : word_adr;
            assign o_mem.cyc = i_core.cyc & cyc_en;

            assign joined_rdt = {o_mem.rdt[HW-1:0], hold_hi};

            assign i_core.rdt = join_rdt ? joined_rdt : o_mem.rdt;
            assign i_core.ack = o_mem.ack & ack_en;

            // Upper half of the first word
            always_ff @(posedge clk) begin
                if (load_hold && o_mem.ack) begin
                    hold_hi <= o_mem.rdt[XW-1 -: HW];
                end
            end

            always_ff @(posedge clk) begin
                if (rst) begin
                    state <= fetch_pkg::ST_IDLE;
                end else begin
                    state <= next_state;
                end
            end

            // Moore outputs
            always_comb begin
                addr_next = 1'b0;
                ack_en    = 1'b1;
                join_rdt  = 1'b0;
                cyc_en    = 1'b1;
                load_hold = 1'b0;
                case (state)
                    fetch_pkg::ST_IDLE: begin
                        // Misaligned request waits a cycle before the first read
                        cyc_en = ~misaligned;
                    end
                    fetch_pkg::ST_FIRST: begin
                        ack_en    = 1'b0;
                        load_hold = 1'b1;
                    end
                    fetch_pkg::ST_SECOND: begin
                        addr_next = 1'b1;
                        join_rdt  = 1'b1;
                    end
                    default: begin
                        cyc_en = 1'b0;
                        ack_en = 1'b0;
                    end
                endcase
            end

            // Next state
            always_comb begin
                next_state = state;
                case (state)
                    fetch_pkg::ST_IDLE: begin
                        if (i_core.cyc && misaligned) begin
                            next_state = fetch_pkg::ST_FIRST;
                        end
                    end
                    fetch_pkg::ST_FIRST: begin
                        if (o_mem.ack) begin
                            next_state = fetch_pkg::ST_SECOND;
                        end
                    end
                    fetch_pkg::ST_SECOND: begin
                        if (o_mem.ack) begin
                            next_state = fetch_pkg::ST_IDLE;
                        end
                    end
                    default: begin
                        next_state = fetch_pkg::ST_IDLE;
                    end
                endcase
            end
        end else begin : g_pass
            // No split, straight through
            assign o_mem.adr  = i_core.adr;
            assign o_mem.cyc  = i_core.cyc;
            assign i_core.rdt = o_mem.rdt;
            assign i_core.ack = o_mem.ack;
        end
    endgenerate

endmodule

// ==== hw/wb_ram.sv ====
`timescale 1ns/1ps
`include "fetch_defs.svh"

module wb_ram (
    input  logic clk,
    input  logic rst,
    mem_if.slave i_bus
);

    localparam int NBYTES = `FETCH_XLEN / 8;

    fetch_pkg::word_t    mem [`FETCH_RAM_WORDS];
    fetch_pkg::word_t    rdt_q;
    fetch_pkg::ram_idx_t idx;
    logic                ack_q;
    logic                take;

    // Word index, wraps at the top of the array
    assign idx = i_bus.adr[`FETCH_RAM_AW+1:2];

    // New request only when no ack is out
    assign take = i_bus.cyc & ~ack_q;

    always_ff @(posedge clk) begin
        if (take && i_bus.we) begin
            for (int b = 0; b < NBYTES; b++) begin
                if (i_bus.sel[b]) begin
                    mem[idx][8*b +: 8] <= i_bus.dat[8*b +: 8];
                end
            end
        end
    end

    // Read word lands with the ack
    always_ff @(posedge clk) begin
        if (take) begin
            rdt_q <= mem[idx];
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ack_q <= 1'b0;
        end else begin
            ack_q <= take;
        end
    end

    assign i_bus.rdt = rdt_q;
    assign i_bus.ack = ack_q;

endmodule
